// File: ecc_arith_unit.sv
/*
 * operand memory with modular adder and
 * bit-serial modular multiplier, busy while multiplying
 */
module ecc_arith_unit #(
    parameter int unsigned Q_MOD = 65521
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    issue_i,
    input  ecc_ctrl_pkg::opcode_e   op_i,
    input  ecc_ctrl_pkg::mem_addr_t dst_i,
    input  ecc_ctrl_pkg::mem_addr_t src_a_i,
    input  ecc_ctrl_pkg::mem_addr_t src_b_i,
    input  ecc_ctrl_pkg::word_t     data_i,
    output ecc_ctrl_pkg::word_t     data_o,
    output logic                    busy_o
);
    import ecc_ctrl_pkg::*;

    localparam word_t Q     = word_t'(Q_MOD);
    localparam int    CNT_W = $clog2(WORD_W);

    word_t            mem [MEM_DEPTH];
    word_t            mul_a;
    word_t            mul_b;
    word_t            acc;
    word_t            acc_dbl;
    word_t            acc_nxt;
    mem_addr_t        mul_dst;
    logic             mul_busy;
    logic [CNT_W-1:0] bit_cnt;

    // both operands are already reduced, so one subtract is enough
    function automatic word_t mod_add(word_t x, word_t y);
        logic [WORD_W:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        if (sum >= {1'b0, Q}) begin
            sum = sum - {1'b0, Q};
        end
        return sum[WORD_W-1:0];
    endfunction

    // ------------------------------
    // msb-first double and add
    assign acc_dbl = mod_add(acc, acc);
    assign acc_nxt = mul_b[WORD_W-1] ? mod_add(acc_dbl, mul_a) : acc_dbl;
    assign busy_o  = mul_busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_busy <= 1'b0;
            bit_cnt  <= '0;
        end else if (zeroize_i) begin
            mul_busy <= 1'b0;
            bit_cnt  <= '0;
        end else if (issue_i && (op_i == UOP_MUL)) begin
            mul_busy <= 1'b1;
            bit_cnt  <= CNT_W'(WORD_W - 1);
        end else if (mul_busy) begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == '0) begin
                mul_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            case (op_i)
                UOP_WR_CORE: mem[dst_i] <= data_i;
                UOP_ADD:     mem[dst_i] <= mod_add(mem[src_a_i], mem[src_b_i]);
                UOP_RD_CORE: data_o <= mem[src_a_i];
                UOP_MUL: begin
                    mul_a   <= mem[src_a_i];
                    mul_b   <= mem[src_b_i];
                    mul_dst <= dst_i;
                    acc     <= '0;
                end
                default: begin
                end
            endcase
        end
        if (mul_busy) begin
            acc   <= acc_nxt;
            mul_b <= {mul_b[WORD_W-2:0], 1'b0};
            if (bit_cnt == '0) begin
                mem[mul_dst] <= acc_nxt;
            end
        end
    end

    // the sequencer has to hold off while a product is in flight
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!reset_n)
        busy_o |-> !issue_i);

endmodule

// File: ecc_ctrl_pkg.sv
/*
 * shared types for the microcoded ECC controller
 * word and address types, command/opcode/register enums,
 * instruction layout and program start addresses
 */
package ecc_ctrl_pkg;

    localparam int WORD_W    = 16;
    localparam int MEM_DEPTH = 8;
    localparam int PC_W      = 6;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;
    typedef logic [PC_W-1:0]              pc_t;

    // command codes as seen on cmd_i
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_KEYGEN,
        CMD_SIGN,
        CMD_VERIFY
    } cmd_e;

    typedef enum logic [2:0] {
        UOP_NOP,
        UOP_WR_CORE,
        UOP_RD_CORE,
        UOP_ADD,
        UOP_MUL,
        UOP_END
    } opcode_e;

    // ids below ID_OUT_PUBKEY are operand sources, the rest are result sinks
    typedef enum logic [3:0] {
        ID_PRIVKEY,
        ID_NONCE,
        ID_MSG,
        ID_PUBKEY,
        ID_SIG_R,
        ID_SIG_S,
        ID_CONST_G,
        ID_OUT_PUBKEY,
        ID_OUT_R,
        ID_OUT_S,
        ID_OUT_VERIFY
    } reg_id_e;

    // one 16-bit microcode word
    typedef struct packed {
        opcode_e   opcode;
        reg_id_e   reg_id;
        mem_addr_t dst;
        mem_addr_t src_a;
        mem_addr_t src_b;
    } instr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HALT
    } fsm_state_e;

    // ---------------------------
    // program entry points
    localparam pc_t PC_RESET  = pc_t'(0);
    localparam pc_t PC_KEYGEN = pc_t'(1);
    localparam pc_t PC_SIGN   = pc_t'(6);
    localparam pc_t PC_VERIFY = pc_t'(16);

endpackage

// File: ecc_dsa_top.sv
/*
 * controller top level
 * ROM, sequencer, arithmetic unit, register bank and range check
 */
module ecc_dsa_top #(
    parameter int unsigned Q_MOD   = 65521,
    parameter int unsigned G_CONST = 7
) (
    input  logic                clk,
    input  logic                reset_n,
    input  ecc_ctrl_pkg::cmd_e  cmd_i,
    input  logic                zeroize_i,
    input  ecc_ctrl_pkg::word_t privkey_i,
    input  ecc_ctrl_pkg::word_t nonce_i,
    input  ecc_ctrl_pkg::word_t msg_i,
    input  ecc_ctrl_pkg::word_t pubkey_i,
    input  ecc_ctrl_pkg::word_t sig_r_i,
    input  ecc_ctrl_pkg::word_t sig_s_i,
    output ecc_ctrl_pkg::word_t pubkey_o,
    output ecc_ctrl_pkg::word_t sig_r_o,
    output ecc_ctrl_pkg::word_t sig_s_o,
    output ecc_ctrl_pkg::word_t verify_o,
    output logic                valid_o,
    output logic                done_o,
    output logic                error_o,
    output logic                ready_o
);
    import ecc_ctrl_pkg::*;

    pc_t    pc;
    instr_t instr;
    word_t  rd_data;
    word_t  wr_data;
    logic   issue;
    logic   busy;
    logic   halt;
    logic   keygen_proc;
    logic   sign_proc;
    logic   verify_proc;
    logic   r_we;
    logic   s_we;

    ecc_seq_rom u_rom (
        .pc_i    (pc),
        .instr_o (instr)
    );

    ecc_seq_fsm u_fsm (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .cmd_i     (cmd_i),
        .instr_i   (instr),
        .busy_i    (busy),
        .halt_i    (halt),
        .pc_o      (pc),
        .issue_o   (issue),
        .ready_o   (ready_o),
        .done_o    (done_o),
        .valid_o   (valid_o),
        .keygen_o  (keygen_proc),
        .sign_o    (sign_proc),
        .verify_o  (verify_proc)
    );

    ecc_arith_unit #(.Q_MOD(Q_MOD)) u_arith (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .issue_i   (issue),
        .op_i      (instr.opcode),
        .dst_i     (instr.dst),
        .src_a_i   (instr.src_a),
        .src_b_i   (instr.src_b),
        .data_i    (wr_data),
        .data_o    (rd_data),
        .busy_o    (busy)
    );

    ecc_reg_bank #(.Q_MOD(Q_MOD), .G_CONST(G_CONST)) u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .issue_i   (issue),
        .op_i      (instr.opcode),
        .reg_id_i  (instr.reg_id),
        .rd_data_i (rd_data),
        .privkey_i (privkey_i),
        .nonce_i   (nonce_i),
        .msg_i     (msg_i),
        .pubkey_i  (pubkey_i),
        .sig_r_i   (sig_r_i),
        .sig_s_i   (sig_s_i),
        .wr_data_o (wr_data),
        .pubkey_o  (pubkey_o),
        .sig_r_o   (sig_r_o),
        .sig_s_o   (sig_s_o),
        .verify_o  (verify_o),
        .r_we_o    (r_we),
        .s_we_o    (s_we)
    );

    ecc_range_check #(.Q_MOD(Q_MOD)) u_check (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .keygen_i  (keygen_proc),
        .sign_i    (sign_proc),
        .verify_i  (verify_proc),
        .privkey_i (privkey_i),
        .pubkey_i  (pubkey_i),
        .sig_r_i   (sig_r_i),
        .sig_s_i   (sig_s_i),
        .r_we_i    (r_we),
        .s_we_i    (s_we),
        .rd_data_i (rd_data),
        .halt_o    (halt),
        .error_o   (error_o)
    );

endmodule

// File: ecc_range_check.sv
/*
 * per-command input and output bound checks with sticky error
 */
module ecc_range_check #(
    parameter int unsigned Q_MOD = 65521
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                keygen_i,
    input  logic                sign_i,
    input  logic                verify_i,
    input  ecc_ctrl_pkg::word_t privkey_i,
    input  ecc_ctrl_pkg::word_t pubkey_i,
    input  ecc_ctrl_pkg::word_t sig_r_i,
    input  ecc_ctrl_pkg::word_t sig_s_i,
    input  logic                r_we_i,
    input  logic                s_we_i,
    input  ecc_ctrl_pkg::word_t rd_data_i,
    output logic                halt_o,
    output logic                error_o
);
    import ecc_ctrl_pkg::*;

    localparam word_t Q = word_t'(Q_MOD);

    logic priv_bad;
    logic out_bad;
    logic sig_bad;
    logic err_live;
    logic err_q;
    logic err_edge;

    // valid scalar lies in 1 .. Q-1
    function automatic logic in_range(word_t v);
        return (v != '0) && (v < Q);
    endfunction

    assign priv_bad = (keygen_i || sign_i) && !in_range(privkey_i);
    assign out_bad  = sign_i && (r_we_i || s_we_i) && (rd_data_i == '0);
    assign sig_bad  = verify_i &&
                      (!in_range(sig_r_i) || !in_range(sig_s_i) || (pubkey_i >= Q));

    assign err_live = priv_bad || out_bad || sig_bad;
    assign err_edge = err_live && !err_q;
    assign halt_o   = err_live || err_q;
    assign error_o  = err_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            err_q <= 1'b0;
        end else if (zeroize_i) begin
            err_q <= 1'b0;
        end else if (err_edge) begin
            err_q <= 1'b1;
        end
    end

endmodule

// File: ecc_reg_bank.sv
/*
 * input operand select, message reduction and
 * result registers written one cycle after the core read
 */
module ecc_reg_bank #(
    parameter int unsigned Q_MOD   = 65521,
    parameter int unsigned G_CONST = 7
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  issue_i,
    input  ecc_ctrl_pkg::opcode_e op_i,
    input  ecc_ctrl_pkg::reg_id_e reg_id_i,
    input  ecc_ctrl_pkg::word_t   rd_data_i,
    input  ecc_ctrl_pkg::word_t   privkey_i,
    input  ecc_ctrl_pkg::word_t   nonce_i,
    input  ecc_ctrl_pkg::word_t   msg_i,
    input  ecc_ctrl_pkg::word_t   pubkey_i,
    input  ecc_ctrl_pkg::word_t   sig_r_i,
    input  ecc_ctrl_pkg::word_t   sig_s_i,
    output ecc_ctrl_pkg::word_t   wr_data_o,
    output ecc_ctrl_pkg::word_t   pubkey_o,
    output ecc_ctrl_pkg::word_t   sig_r_o,
    output ecc_ctrl_pkg::word_t   sig_s_o,
    output ecc_ctrl_pkg::word_t   verify_o,
    output logic                  r_we_o,
    output logic                  s_we_o
);
    import ecc_ctrl_pkg::*;

    localparam word_t Q = word_t'(Q_MOD);
    localparam word_t G = word_t'(G_CONST);

    word_t   msg_red;
    reg_id_e rd_id_q;
    logic    rd_strobe;
    logic    rd_q;

    assign rd_strobe = issue_i && (op_i == UOP_RD_CORE);
    assign r_we_o    = rd_q && (rd_id_q == ID_OUT_R);
    assign s_we_o    = rd_q && (rd_id_q == ID_OUT_S);

    // operand for a core write
    always_comb begin
        wr_data_o = '0;
        if (op_i == UOP_WR_CORE) begin
            case (reg_id_i)
                ID_PRIVKEY: wr_data_o = privkey_i;
                ID_NONCE:   wr_data_o = nonce_i;
                ID_MSG:     wr_data_o = msg_red;
                ID_PUBKEY:  wr_data_o = pubkey_i;
                ID_SIG_R:   wr_data_o = sig_r_i;
                ID_SIG_S:   wr_data_o = sig_s_i;
                ID_CONST_G: wr_data_o = G;
                default:    wr_data_o = '0;
            endcase
        end
    end

    // a 16-bit message is below 2Q, one subtract reduces it
    always_ff @(posedge clk) begin
        msg_red <= (msg_i >= Q) ? msg_i - Q : msg_i;
        if (rd_strobe) begin
            rd_id_q <= reg_id_i;
        end
    end

    // ------------------------------
    // write-back, core read data lands one cycle after the strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_q     <= 1'b0;
            pubkey_o <= '0;
            sig_r_o  <= '0;
            sig_s_o  <= '0;
            verify_o <= '0;
        end else if (zeroize_i) begin
            rd_q     <= 1'b0;
            pubkey_o <= '0;
            sig_r_o  <= '0;
            sig_s_o  <= '0;
            verify_o <= '0;
        end else begin
            rd_q <= rd_strobe;
            if (rd_q) begin
                case (rd_id_q)
                    ID_OUT_PUBKEY: pubkey_o <= rd_data_i;
                    ID_OUT_R:      sig_r_o  <= rd_data_i;
                    ID_OUT_S:      sig_s_o  <= rd_data_i;
                    ID_OUT_VERIFY: verify_o <= rd_data_i;
                    default: begin
                    end
                endcase
            end
        end
    end

    // the settle gap keeps back-to-back reads apart
    a_rd_mutex: assert property (@(posedge clk) disable iff (!reset_n)
        !(rd_strobe && rd_q));

endmodule

// File: ecc_seq_fsm.sv
/*
 * command dispatch and program sequencer
 * program counter, settle count, process flags, done/valid status
 */
module ecc_seq_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  ecc_ctrl_pkg::cmd_e   cmd_i,
    input  ecc_ctrl_pkg::instr_t instr_i,
    input  logic                 busy_i,
    input  logic                 halt_i,
    output ecc_ctrl_pkg::pc_t    pc_o,
    output logic                 issue_o,
    output logic                 ready_o,
    output logic                 done_o,
    output logic                 valid_o,
    output logic                 keygen_o,
    output logic                 sign_o,
    output logic                 verify_o
);
    import ecc_ctrl_pkg::*;

    fsm_state_e state;
    logic [1:0] settle_cnt;

    // an instruction goes out only on a quiet boundary
    assign issue_o = (state == ST_RUN) && (settle_cnt == 2'd0) && !busy_i && !halt_i;
    assign ready_o = (state != ST_RUN);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= ST_IDLE;
            pc_o       <= PC_RESET;
            settle_cnt <= 2'd0;
            done_o     <= 1'b0;
            valid_o    <= 1'b0;
            keygen_o   <= 1'b0;
            sign_o     <= 1'b0;
            verify_o   <= 1'b0;
        end else if (zeroize_i) begin
            state      <= ST_IDLE;
            pc_o       <= PC_RESET;
            settle_cnt <= 2'd0;
            done_o     <= 1'b0;
            valid_o    <= 1'b0;
            keygen_o   <= 1'b0;
            sign_o     <= 1'b0;
            verify_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (halt_i) begin
                // sticky until zeroize
                state      <= ST_HALT;
                pc_o       <= PC_RESET;
                settle_cnt <= 2'd0;
                keygen_o   <= 1'b0;
                sign_o     <= 1'b0;
                verify_o   <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (cmd_i != CMD_NONE) begin
                            state      <= ST_RUN;
                            valid_o    <= 1'b0;
                            settle_cnt <= 2'd0;
                        end
                        keygen_o <= (cmd_i == CMD_KEYGEN);
                        sign_o   <= (cmd_i == CMD_SIGN);
                        verify_o <= (cmd_i == CMD_VERIFY);
                        case (cmd_i)
                            CMD_KEYGEN: pc_o <= PC_KEYGEN;
                            CMD_SIGN:   pc_o <= PC_SIGN;
                            CMD_VERIFY: pc_o <= PC_VERIFY;
                            default:    pc_o <= PC_RESET;
                        endcase
                    end
                    ST_RUN: begin
                        if (busy_i) begin
                            // stall, then settle again once the unit frees up
                            settle_cnt <= 2'd3;
                        end else if (settle_cnt != 2'd0) begin
                            settle_cnt <= settle_cnt - 2'd1;
                        end else if (instr_i.opcode == UOP_END) begin
                            state    <= ST_IDLE;
                            pc_o     <= PC_RESET;
                            done_o   <= 1'b1;
                            valid_o  <= 1'b1;
                            keygen_o <= 1'b0;
                            sign_o   <= 1'b0;
                            verify_o <= 1'b0;
                        end else begin
                            pc_o       <= pc_o + 1'b1;
                            settle_cnt <= 2'd3;
                        end
                    end
                    default: begin
                        // ST_HALT only leaves on zeroize
                    end
                endcase
            end
        end
    end

    // a command arriving mid-program must not move the program counter
    a_no_jump_in_run: assert property (@(posedge clk) disable iff (!reset_n)
        (state == ST_RUN) ##1 (state == ST_RUN) |->
            (pc_o == $past(pc_o)) || (pc_o == pc_t'($past(pc_o) + 1'b1)));

endmodule

// File: ecc_seq_rom.sv
/*
 * microcode program ROM
 * keygen, sign and verify programs behind a reset NOP
 */
module ecc_seq_rom (
    input  ecc_ctrl_pkg::pc_t    pc_i,
    output ecc_ctrl_pkg::instr_t instr_o
);
    import ecc_ctrl_pkg::*;

    function automatic instr_t mk(opcode_e op, reg_id_e id, mem_addr_t d,
                                  mem_addr_t a, mem_addr_t b);
        instr_t w;
        w.opcode = op;
        w.reg_id = id;
        w.dst    = d;
        w.src_a  = a;
        w.src_b  = b;
        return w;
    endfunction

    always_comb begin
        case (pc_i)
            // ---------------------------
            // keygen: pubkey = privkey * G
            6'd1:  instr_o = mk(UOP_WR_CORE, ID_PRIVKEY,    3'd0, 3'd0, 3'd0);
            6'd2:  instr_o = mk(UOP_WR_CORE, ID_CONST_G,    3'd1, 3'd0, 3'd0);
            6'd3:  instr_o = mk(UOP_MUL,     ID_PRIVKEY,    3'd2, 3'd0, 3'd1);
            6'd4:  instr_o = mk(UOP_RD_CORE, ID_OUT_PUBKEY, 3'd0, 3'd2, 3'd0);
            6'd5:  instr_o = mk(UOP_END,     ID_PRIVKEY,    3'd0, 3'd0, 3'd0);
            // ---------------------------
            // sign: r = nonce * G, s = msg + privkey * r
            6'd6:  instr_o = mk(UOP_WR_CORE, ID_NONCE,      3'd0, 3'd0, 3'd0);
            6'd7:  instr_o = mk(UOP_WR_CORE, ID_CONST_G,    3'd1, 3'd0, 3'd0);
            6'd8:  instr_o = mk(UOP_MUL,     ID_PRIVKEY,    3'd2, 3'd0, 3'd1);
            6'd9:  instr_o = mk(UOP_RD_CORE, ID_OUT_R,      3'd0, 3'd2, 3'd0);
            6'd10: instr_o = mk(UOP_WR_CORE, ID_PRIVKEY,    3'd3, 3'd0, 3'd0);
            6'd11: instr_o = mk(UOP_MUL,     ID_PRIVKEY,    3'd4, 3'd3, 3'd2);
            6'd12: instr_o = mk(UOP_WR_CORE, ID_MSG,        3'd5, 3'd0, 3'd0);
            6'd13: instr_o = mk(UOP_ADD,     ID_PRIVKEY,    3'd6, 3'd5, 3'd4);
            6'd14: instr_o = mk(UOP_RD_CORE, ID_OUT_S,      3'd0, 3'd6, 3'd0);
            6'd15: instr_o = mk(UOP_END,     ID_PRIVKEY,    3'd0, 3'd0, 3'd0);
            // ---------------------------
            // verify: v = s * G + msg * pubkey
            6'd16: instr_o = mk(UOP_WR_CORE, ID_SIG_S,      3'd0, 3'd0, 3'd0);
            6'd17: instr_o = mk(UOP_WR_CORE, ID_CONST_G,    3'd1, 3'd0, 3'd0);
            6'd18: instr_o = mk(UOP_MUL,     ID_PRIVKEY,    3'd2, 3'd0, 3'd1);
            6'd19: instr_o = mk(UOP_WR_CORE, ID_MSG,        3'd3, 3'd0, 3'd0);
            6'd20: instr_o = mk(UOP_WR_CORE, ID_PUBKEY,     3'd4, 3'd0, 3'd0);
            6'd21: instr_o = mk(UOP_MUL,     ID_PRIVKEY,    3'd5, 3'd3, 3'd4);
            6'd22: instr_o = mk(UOP_ADD,     ID_PRIVKEY,    3'd6, 3'd2, 3'd5);
            6'd23: instr_o = mk(UOP_RD_CORE, ID_OUT_VERIFY, 3'd0, 3'd6, 3'd0);
            6'd24: instr_o = mk(UOP_END,     ID_PRIVKEY,    3'd0, 3'd0, 3'd0);
            // address 0 is the reset slot the sequencer parks on
            default: instr_o = mk(UOP_NOP, ID_PRIVKEY, 3'd0, 3'd0, 3'd0);
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the ECC controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ecc_dsa -o tb_ecc_dsa
./obj_dir/tb_ecc_dsa | tee sim.log
if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: tb_ecc_dsa.sv
/*
 * testbench for the microcoded ECC controller
 * random keygen/sign/verify against a modular reference model,
 * range errors, zeroize recovery and command drop while busy
 */
module tb_ecc_dsa;
    import ecc_ctrl_pkg::*;

    localparam int unsigned Q       = 65521;
    localparam int unsigned G       = 7;
    localparam int          TIMEOUT = 400;
    localparam int          N_RAND  = 6;

    logic  clk;
    logic  reset_n;
    cmd_e  cmd_i;
    logic  zeroize_i;
    word_t privkey_i;
    word_t nonce_i;
    word_t msg_i;
    word_t pubkey_i;
    word_t sig_r_i;
    word_t sig_s_i;
    word_t pubkey_o;
    word_t sig_r_o;
    word_t sig_s_o;
    word_t verify_o;
    logic  valid_o;
    logic  done_o;
    logic  error_o;
    logic  ready_o;

    int          errors;
    int          err_mark;
    int          tests;
    int          tests_failed;

    ecc_dsa_top #(.Q_MOD(Q), .G_CONST(G)) u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_i     (cmd_i),
        .zeroize_i (zeroize_i),
        .privkey_i (privkey_i),
        .nonce_i   (nonce_i),
        .msg_i     (msg_i),
        .pubkey_i  (pubkey_i),
        .sig_r_i   (sig_r_i),
        .sig_s_i   (sig_s_i),
        .pubkey_o  (pubkey_o),
        .sig_r_o   (sig_r_o),
        .sig_s_o   (sig_s_o),
        .verify_o  (verify_o),
        .valid_o   (valid_o),
        .done_o    (done_o),
        .error_o   (error_o),
        .ready_o   (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // reference model, plain integer arithmetic mod Q
    function automatic word_t mul_mod(word_t a, word_t b);
        return word_t'((64'(a) * 64'(b)) % Q);
    endfunction

    function automatic word_t add_mod(word_t a, word_t b);
        return word_t'((32'(a) + 32'(b)) % Q);
    endfunction

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // inputs stay as set here until the next command
    task automatic start_cmd(cmd_e c, word_t k, word_t n, word_t m, word_t p,
                             word_t r, word_t s);
        @(negedge clk);
        privkey_i = k;
        nonce_i   = n;
        msg_i     = m;
        pubkey_i  = p;
        sig_r_i   = r;
        sig_s_i   = s;
        cmd_i     = c;
        @(negedge clk);
        cmd_i = CMD_NONE;
    endtask

    task automatic wait_result(string name, output logic got_done, output logic got_err);
        int n;
        got_done = 1'b0;
        got_err  = 1'b0;
        n        = 0;
        while (!got_done && !got_err && n < TIMEOUT) begin
            @(negedge clk);
            got_done = done_o;
            got_err  = error_o;
            n++;
        end
        if (!got_done && !got_err) begin
            $display("timeout: %s ended with neither done nor error", name);
            errors++;
        end
    endtask

    task automatic count_done(int cycles, output int n_done);
        n_done = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (done_o) n_done++;
        end
    endtask

    task automatic zeroize_pulse();
        @(negedge clk);
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i = 1'b0;
        check_flag("error_o after zeroize", error_o, 1'b0);
        check_flag("valid_o after zeroize", valid_o, 1'b0);
        check_flag("ready_o after zeroize", ready_o, 1'b1);
    endtask

    task automatic finish_test(string name);
        tests++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
        err_mark = errors;
    endtask

    // ------------------------------
    task automatic keygen_case(word_t k);
        logic d;
        logic e;
        start_cmd(CMD_KEYGEN, k, '0, '0, '0, '0, '0);
        wait_result("keygen", d, e);
        check_flag("keygen done_o", d, 1'b1);
        check_flag("keygen error_o", error_o, 1'b0);
        check_flag("keygen valid_o", valid_o, 1'b1);
        check_word("pubkey_o", pubkey_o, mul_mod(k, word_t'(G)));
    endtask

    task automatic sign_case(word_t k, word_t n, word_t m);
        word_t r;
        word_t s;
        logic  d;
        logic  e;
        r = mul_mod(n, word_t'(G));
        s = add_mod(word_t'(m % Q), mul_mod(k, r));
        start_cmd(CMD_SIGN, k, n, m, '0, '0, '0);
        wait_result("sign", d, e);
        if (r == '0 || s == '0) begin
            // a zero r or s has to stop the command
            check_flag("sign error_o", e, 1'b1);
            check_flag("sign done_o", d, 1'b0);
            zeroize_pulse();
        end else begin
            check_flag("sign done_o", d, 1'b1);
            check_flag("sign error_o", error_o, 1'b0);
            check_word("sig_r_o", sig_r_o, r);
            check_word("sig_s_o", sig_s_o, s);
        end
    endtask

    task automatic verify_case(word_t p, word_t r, word_t s, word_t m);
        logic d;
        logic e;
        start_cmd(CMD_VERIFY, '1, '0, m, p, r, s);
        wait_result("verify", d, e);
        check_flag("verify done_o", d, 1'b1);
        check_flag("verify error_o", error_o, 1'b0);
        check_word("verify_o", verify_o,
                   add_mod(mul_mod(s, word_t'(G)), mul_mod(word_t'(m % Q), p)));
    endtask

    task automatic range_case(string name, cmd_e c, word_t k, word_t p, word_t r);
        logic d;
        logic e;
        int   n_done;
        start_cmd(c, k, 16'd3, 16'd5, p, r, 16'd1);
        wait_result(name, d, e);
        check_flag("range error_o", e, 1'b1);
        check_flag("range done_o", d, 1'b0);
        check_flag("ready_o while halted", ready_o, 1'b1);
        // a good command must still be ignored
        start_cmd(CMD_KEYGEN, 16'd100, '0, '0, '0, '0, '0);
        count_done(TIMEOUT, n_done);
        check_flag("no done while halted", n_done == 0, 1'b1);
        check_flag("error_o held", error_o, 1'b1);
        zeroize_pulse();
    endtask

    initial begin
        word_t k;
        word_t n;
        word_t m;
        logic  d;
        logic  e;
        int    n_done;
        void'($urandom(97));
        reset_n      = 1'b0;
        cmd_i        = CMD_NONE;
        zeroize_i    = 1'b0;
        privkey_i    = '0;
        nonce_i      = '0;
        msg_i        = '0;
        pubkey_i     = '0;
        sig_r_i      = '0;
        sig_s_i      = '0;
        errors       = 0;
        err_mark     = 0;
        tests        = 0;
        tests_failed = 0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        check_flag("ready_o after reset", ready_o, 1'b1);
        check_flag("valid_o after reset", valid_o, 1'b0);
        check_flag("done_o after reset", done_o, 1'b0);
        check_flag("error_o after reset", error_o, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            keygen_case(word_t'(1 + $urandom % (Q - 1)));
            finish_test("keygen");
        end
        for (int i = 0; i < N_RAND; i++) begin
            k = word_t'(1 + $urandom % (Q - 1));
            n = word_t'($urandom % Q);
            m = (i % 2 == 1) ? word_t'(Q + $urandom % (65536 - Q)) : word_t'($urandom);
            // last round picks the message so that s comes out zero
            if (i == N_RAND - 1) m = word_t'((Q - mul_mod(k, mul_mod(n, word_t'(G)))) % Q);
            sign_case(k, n, m);
            finish_test("sign");
        end
        for (int i = 0; i < N_RAND; i++) begin
            verify_case(word_t'($urandom % Q), word_t'(1 + $urandom % (Q - 1)),
                        word_t'(1 + $urandom % (Q - 1)), word_t'($urandom));
            finish_test("verify");
        end

        range_case("zero privkey", CMD_KEYGEN, '0, '0, '0);
        finish_test("range zero privkey");
        range_case("r above Q", CMD_VERIFY, '0, 16'd9, word_t'(Q + 3));
        finish_test("range sig r");
        range_case("pubkey above Q", CMD_VERIFY, '0, word_t'(Q), 16'd11);
        finish_test("range pubkey");

        start_cmd(CMD_SIGN, '0, 16'd4, 16'd6, '0, '0, '0);
        wait_result("recovery error", d, e);
        check_flag("recovery error_o", e, 1'b1);
        zeroize_pulse();
        keygen_case(word_t'(1 + $urandom % (Q - 1)));
        // a completed result has valid_o high, zeroize must drop it
        zeroize_pulse();
        finish_test("recovery");

        k = word_t'(1 + $urandom % (Q - 1));
        start_cmd(CMD_KEYGEN, k, '0, '0, '0, '0, '0);
        check_flag("ready_o while running", ready_o, 1'b0);
        start_cmd(CMD_SIGN, k, '0, '0, '0, '0, '0);
        wait_result("busy keygen", d, e);
        check_flag("busy done_o", d, 1'b1);
        count_done(TIMEOUT, n_done);
        check_flag("single done", n_done == 0, 1'b1);
        check_word("busy pubkey_o", pubkey_o, mul_mod(k, word_t'(G)));
        finish_test("busy drop");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
ecc_ctrl_pkg.sv
ecc_seq_rom.sv
ecc_seq_fsm.sv
ecc_arith_unit.sv
ecc_reg_bank.sv
ecc_range_check.sv
ecc_dsa_top.sv
tb_ecc_dsa.sv
